// File: common/mapper_config.svh
`ifndef MAPPER_CONFIG_SVH
`define MAPPER_CONFIG_SVH

// --------------------------------------------------
// Raster and board geometry
// --------------------------------------------------
`define BOARD_LEFT     80
`define BOARD_RIGHT    560
`define SCREEN_HEIGHT  480
`define TILE_SIZE      30
`define GRID_DIM       16

// Field widths
`define COORD_W        10
`define TILE_W         4
`define ADDR_W         8
`define STATE_W        4

// --------------------------------------------------
// Fixed player colours, as palette indices
// --------------------------------------------------
`define P1_COLOR_INDEX 13
`define P2_COLOR_INDEX 14

`endif

// File: common/boardPkg.sv
`include "mapper_config.svh"

package boardPkg;

    // --------------------------------------------------
    // Raster and board positions
    // --------------------------------------------------

    // Pixel coordinate on the 640x480 raster
    typedef logic [`COORD_W-1:0] coordT;

    // Tile column or row on the 16x16 grid
    typedef logic [`TILE_W-1:0] tileIdxT;

    // Row-major board RAM address
    typedef logic [`ADDR_W-1:0] boardAddrT;

    // Cell content as stored in the board RAM
    typedef logic [`STATE_W-1:0] tileStateT;

    // --------------------------------------------------
    // Pixel classification
    // --------------------------------------------------
    typedef enum logic [1:0] {
        BORDER     = 2'd0,
        BOARD_TILE = 2'd1,
        PLAYER_ONE = 2'd2,
        PLAYER_TWO = 2'd3
    } pixelKindT;

endpackage

// File: common/colorPkg.sv
`include "mapper_config.svh"

package colorPkg;

    // Board state doubles as a palette index
    typedef logic [`STATE_W-1:0] paletteIdxT;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } rgbT;

    // --------------------------------------------------
    // Tile palette
    // --------------------------------------------------
    localparam rgbT PALETTE [16] = '{
        24'hAAC82F,  // grass
        24'hAAC82F,  // grass as well
        24'h3CABDD,
        24'h93CF81,
        24'h98E7D8,
        24'h37E2D5,
        24'h22BBE6,
        24'hFCC656,
        24'hA87C07,
        24'hCB8C1A,
        24'hE78924,
        24'hF2AB45,
        24'hA0611F,
        24'h0964C8,  // player 1
        24'hFBFEF2,  // player 2
        24'h39403A
    };

    // Side strips, also shown out of reset
    localparam rgbT BORDER_COLOR = 24'hAAEA66;

endpackage

// File: rtl/tileLocator.sv
`timescale 1ns/10ps
`include "mapper_config.svh"

module tileLocator import boardPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  coordT     drawX,
    input  coordT     drawY,
    output tileIdxT   tileX,
    output tileIdxT   tileY,
    output logic      onBoard,
    output boardAddrT boardAddr
);

    logic      inBoard;
    coordT     offsetX;
    tileIdxT   colNext;
    tileIdxT   rowNext;
    boardAddrT addrNext;

    // Board spans columns 80 to 559 and every visible row
    assign inBoard = (drawX >= coordT'(`BOARD_LEFT)) &&
                     (drawX < coordT'(`BOARD_RIGHT)) &&
                     (drawY < coordT'(`SCREEN_HEIGHT));

    assign offsetX = drawX - coordT'(`BOARD_LEFT);

    always_comb begin
        if (inBoard) begin
            colNext = tileIdxT'(offsetX / `TILE_SIZE);
            rowNext = tileIdxT'(drawY / `TILE_SIZE);
        end else begin
            colNext = '0;
            rowNext = '0;
        end
        // Row-major, so off-board pixels land on address 0
        addrNext = boardAddrT'(rowNext * `GRID_DIM + colNext);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            onBoard   <= 1'b0;
            boardAddr <= '0;
        end else begin
            onBoard   <= inBoard;
            boardAddr <= addrNext;
        end
    end

    always_ff @(posedge clk) begin
        tileX <= colNext;
        tileY <= rowNext;
    end

endmodule

// File: rtl/tileClassifier.sv
`timescale 1ns/10ps
`include "mapper_config.svh"

module tileClassifier import boardPkg::*, colorPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  tileIdxT    tileX,
    input  tileIdxT    tileY,
    input  logic       onBoard,
    input  tileStateT  boardState,
    input  tileIdxT    p1TileX,
    input  tileIdxT    p1TileY,
    input  tileIdxT    p2TileX,
    input  tileIdxT    p2TileY,
    output pixelKindT  kind,
    output paletteIdxT paletteIdx
);

    tileIdxT    tileXQ;
    tileIdxT    tileYQ;
    logic       onBoardQ;
    logic       hitP1;
    logic       hitP2;
    pixelKindT  kindNext;
    paletteIdxT idxNext;

    // --------------------------------------------------
    // Align tile position with the RAM read data
    // --------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            onBoardQ <= 1'b0;
        end else begin
            onBoardQ <= onBoard;
        end
    end

    always_ff @(posedge clk) begin
        tileXQ <= tileX;
        tileYQ <= tileY;
    end

    assign hitP1 = (tileXQ == p1TileX) && (tileYQ == p1TileY);
    assign hitP2 = (tileXQ == p2TileX) && (tileYQ == p2TileY);

    // Player 1 wins a shared tile
    always_comb begin
        if (!onBoardQ) begin
            kindNext = BORDER;
            idxNext  = '0;
        end else if (hitP1) begin
            kindNext = PLAYER_ONE;
            idxNext  = paletteIdxT'(`P1_COLOR_INDEX);
        end else if (hitP2) begin
            kindNext = PLAYER_TWO;
            idxNext  = paletteIdxT'(`P2_COLOR_INDEX);
        end else begin
            kindNext = BOARD_TILE;
            idxNext  = paletteIdxT'(boardState);
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            kind <= BORDER;
        end else begin
            kind <= kindNext;
        end
    end

    always_ff @(posedge clk) begin
        paletteIdx <= idxNext;
    end

endmodule

// File: rtl/paletteLookup.sv
`timescale 1ns/10ps

module paletteLookup import boardPkg::*, colorPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  pixelKindT  kind,
    input  paletteIdxT paletteIdx,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    rgbT colorNext;
    rgbT colorQ;

    // --------------------------------------------------
    // Colour select
    // --------------------------------------------------
    always_comb begin
        case (kind)
            BORDER: begin
                colorNext = BORDER_COLOR;
            end
            BOARD_TILE,
            PLAYER_ONE,
            PLAYER_TWO: begin
                colorNext = PALETTE[paletteIdx];
            end
            default: begin
                colorNext = BORDER_COLOR;
            end
        endcase
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------

    // Border colour until the first pixel makes it through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            colorQ <= BORDER_COLOR;
        end else begin
            colorQ <= colorNext;
        end
    end

    assign red   = colorQ.red;
    assign green = colorQ.green;
    assign blue  = colorQ.blue;

endmodule

// File: rtl/colorMapper.sv
`timescale 1ns/10ps

module colorMapper import boardPkg::*, colorPkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  coordT      drawX,
    input  coordT      drawY,
    input  tileIdxT    p1TileX,
    input  tileIdxT    p1TileY,
    input  tileIdxT    p2TileX,
    input  tileIdxT    p2TileY,
    output boardAddrT  boardAddr,
    input  tileStateT  boardState,
    output logic [7:0] red,
    output logic [7:0] green,
    output logic [7:0] blue
);

    // Stage 1 to stage 2
    tileIdxT    tileX;
    tileIdxT    tileY;
    logic       onBoard;

    // Stage 2 to stage 3
    pixelKindT  kind;
    paletteIdxT paletteIdx;

    tileLocator tileLocator_i (
        .clk       (clk),
        .rst       (rst),
        .drawX     (drawX),
        .drawY     (drawY),
        .tileX     (tileX),
        .tileY     (tileY),
        .onBoard   (onBoard),
        .boardAddr (boardAddr)
    );

    tileClassifier tileClassifier_i (
        .clk        (clk),
        .rst        (rst),
        .tileX      (tileX),
        .tileY      (tileY),
        .onBoard    (onBoard),
        .boardState (boardState),
        .p1TileX    (p1TileX),
        .p1TileY    (p1TileY),
        .p2TileX    (p2TileX),
        .p2TileY    (p2TileY),
        .kind       (kind),
        .paletteIdx (paletteIdx)
    );

    paletteLookup paletteLookup_i (
        .clk        (clk),
        .rst        (rst),
        .kind       (kind),
        .paletteIdx (paletteIdx),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

endmodule

// File: tb/colorMapperTb.sv
`timescale 1ns/10ps
`include "mapper_config.svh"

module colorMapperTb import boardPkg::*, colorPkg::*; ();

    localparam int RESET_CYCLES  = 10;
    localparam int STREAM_PIXELS = 2000;
    localparam int SCREEN_WIDTH  = 640;
    // Several times the length of the whole run
    localparam int TIMEOUT_CYCLES = 8 * (STREAM_PIXELS + 500);
    localparam rgbT GRASS = 24'hAAC82F;

    logic       clk;
    logic       rst;
    coordT      drawX;
    coordT      drawY;
    tileIdxT    p1TileX;
    tileIdxT    p1TileY;
    tileIdxT    p2TileX;
    tileIdxT    p2TileY;
    boardAddrT  boardAddr;
    tileStateT  boardState;
    logic [7:0] red;
    logic [7:0] green;
    logic [7:0] blue;

    tileStateT   boardMem [256];
    rgbT         expQ [$];
    int          expXQ [$];
    int          expYQ [$];
    logic [15:0] playerPipe [2];
    tileIdxT     curP1X;
    tileIdxT     curP1Y;
    tileIdxT     curP2X;
    tileIdxT     curP2Y;
    int          lastX;
    int          lastY;
    logic [15:0] lfsrState;
    int          checkCount;
    int          errorCount;
    int          cycleCount;

    colorMapper colorMapper_i (
        .clk        (clk),
        .rst        (rst),
        .drawX      (drawX),
        .drawY      (drawY),
        .p1TileX    (p1TileX),
        .p1TileY    (p1TileY),
        .p2TileX    (p2TileX),
        .p2TileY    (p2TileY),
        .boardAddr  (boardAddr),
        .boardState (boardState),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    always #4 clk = ~clk;

    // Board RAM with one cycle of read latency
    always @(posedge clk) begin
        boardState <= boardMem[boardAddr];
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $finish;
        end
    end

    // --------------------------------------------------
    // Stimulus source and reference model
    // --------------------------------------------------

    // Galois LFSR stepped once per bit taken
    function automatic int randomBits(input int count);
        int   value;
        int   i;
        logic lsb;
        value = 0;
        for (i = 0; i < count; i++) begin
            lsb = lfsrState[0];
            lfsrState = lfsrState >> 1;
            if (lsb) begin
                lfsrState = lfsrState ^ 16'hB400;
            end
            value = (value << 1) | lsb;
        end
        return value;
    endfunction

    function automatic rgbT refColor(input int x, input int y);
        int col;
        int row;
        if (x < `BOARD_LEFT || x >= `BOARD_RIGHT || y >= `SCREEN_HEIGHT) begin
            return BORDER_COLOR;
        end
        col = (x - `BOARD_LEFT) / `TILE_SIZE;
        row = y / `TILE_SIZE;
        if (col == curP1X && row == curP1Y) begin
            return PALETTE[`P1_COLOR_INDEX];
        end
        if (col == curP2X && row == curP2Y) begin
            return PALETTE[`P2_COLOR_INDEX];
        end
        return PALETTE[boardMem[row * `GRID_DIM + col]];
    endfunction

    // Off-board pixels read address 0
    function automatic boardAddrT refAddr(input int x, input int y);
        int col;
        int row;
        if (x < `BOARD_LEFT || x >= `BOARD_RIGHT || y >= `SCREEN_HEIGHT) begin
            return '0;
        end
        col = (x - `BOARD_LEFT) / `TILE_SIZE;
        row = y / `TILE_SIZE;
        return boardAddrT'(row * `GRID_DIM + col);
    endfunction

    // Row plus column modulo 16 gives row 0 every state
    task automatic fillBoard();
        int a;
        for (a = 0; a < 256; a++) begin
            boardMem[a] = tileStateT'((a + a / 16) % 16);
        end
    endtask

    task automatic setPlayers(input int ax, input int ay, input int bx, input int by);
        curP1X = tileIdxT'(ax);
        curP1Y = tileIdxT'(ay);
        curP2X = tileIdxT'(bx);
        curP2Y = tileIdxT'(by);
    endtask

    task automatic compareColor(input string where, input rgbT want);
        checkCount++;
        if ({red, green, blue} !== want) begin
            errorCount++;
            $display("CHECK FAILED {red,green,blue} %s: got %h, expected %h",
                     where, {red, green, blue}, want);
        end
    endtask

    task automatic compareAddr(input string where, input boardAddrT want);
        checkCount++;
        if (boardAddr !== want) begin
            errorCount++;
            $display("CHECK FAILED boardAddr %s: got %h, expected %h",
                     where, boardAddr, want);
        end
    endtask

    // --------------------------------------------------
    // Pixel driver
    // --------------------------------------------------

    // Players trail their pixel by two cycles to meet the classifier compare
    task automatic presentPixel(input int x, input int y, input rgbT want);
        rgbT wantNow;
        int  wx;
        int  wy;
        @(posedge clk);
        drawX <= coordT'(x);
        drawY <= coordT'(y);
        {p1TileX, p1TileY, p2TileX, p2TileY} <= playerPipe[1];
        playerPipe[1] = playerPipe[0];
        playerPipe[0] = {curP1X, curP1Y, curP2X, curP2Y};
        expQ.push_back(want);
        expXQ.push_back(x);
        expYQ.push_back(y);
        @(negedge clk);
        // Address of the previous pixel is out after one edge
        compareAddr($sformatf("at pixel (%0d,%0d)", lastX, lastY), refAddr(lastX, lastY));
        lastX = x;
        lastY = y;
        if (expQ.size() > 4) begin
            wantNow = expQ.pop_front();
            wx = expXQ.pop_front();
            wy = expYQ.pop_front();
            compareColor($sformatf("at pixel (%0d,%0d)", wx, wy), wantNow);
        end
    endtask

    task automatic presentModeled(input int x, input int y);
        presentPixel(x, y, refColor(x, y));
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic verifyReset();
        int i;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            compareColor("during reset", BORDER_COLOR);
            compareAddr("during reset", '0);
        end
        @(posedge clk);
        rst <= 1'b0;
        // Pipeline still holds reset state for four cycles
        for (i = 0; i < 4; i++) begin
            expQ.push_back(BORDER_COLOR);
            expXQ.push_back(0);
            expYQ.push_back(0);
        end
    endtask

    task automatic borderColumns();
        int cols [4];
        int rows [3];
        int c;
        int r;
        cols = '{0, 79, 560, 639};
        rows = '{480, 500, 1023};
        setPlayers(15, 15, 15, 15);
        for (c = 0; c < 4; c++) begin
            presentPixel(cols[c], 0, BORDER_COLOR);
            presentPixel(cols[c], 240, BORDER_COLOR);
            presentPixel(cols[c], 479, BORDER_COLOR);
        end
        for (r = 0; r < 3; r++) begin
            presentPixel(80, rows[r], BORDER_COLOR);
            presentPixel(300, rows[r], BORDER_COLOR);
            presentPixel(559, rows[r], BORDER_COLOR);
        end
    endtask

    task automatic tileStates();
        int col;
        int x;
        setPlayers(15, 15, 15, 15);
        for (col = 0; col < `GRID_DIM; col++) begin
            x = `BOARD_LEFT + col * `TILE_SIZE + 15;
            if (col < 2) begin
                presentPixel(x, 15, GRASS);
            end else begin
                presentModeled(x, 15);
            end
        end
    endtask

    task automatic playerOverlay();
        setPlayers(3, 2, 7, 5);
        presentPixel(180, 70, PALETTE[`P1_COLOR_INDEX]);
        presentPixel(310, 170, PALETTE[`P2_COLOR_INDEX]);
        presentModeled(211, 70);
        // Player 1 on top of a shared tile
        setPlayers(9, 9, 9, 9);
        presentPixel(355, 285, PALETTE[`P1_COLOR_INDEX]);
    endtask

    task automatic tileEdges();
        setPlayers(15, 15, 15, 15);
        presentModeled(109, 45);
        presentModeled(110, 45);
        presentModeled(200, 29);
        presentModeled(200, 30);
        presentModeled(559, 100);
        presentPixel(560, 100, BORDER_COLOR);
    endtask

    task automatic randomStream();
        int i;
        int x;
        int y;
        for (i = 0; i < STREAM_PIXELS; i++) begin
            if (i % 4 == 0) begin
                setPlayers(randomBits(4), randomBits(4), randomBits(4), randomBits(4));
            end
            x = randomBits(10) % SCREEN_WIDTH;
            y = randomBits(9);
            presentModeled(x, y);
        end
    endtask

    task automatic drainPipeline();
        setPlayers(15, 15, 15, 15);
        repeat (4) begin
            presentPixel(0, 0, BORDER_COLOR);
        end
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        drawX = '0;
        drawY = '0;
        p1TileX = '0;
        p1TileY = '0;
        p2TileX = '0;
        p2TileY = '0;
        boardState = '0;
        playerPipe[0] = '0;
        playerPipe[1] = '0;
        lastX = 0;
        lastY = 0;
        lfsrState = 16'd88;
        checkCount = 0;
        errorCount = 0;
        cycleCount = 0;
        setPlayers(0, 0, 0, 0);
        fillBoard();
        verifyReset();
        borderColumns();
        tileStates();
        playerOverlay();
        tileEdges();
        randomStream();
        drainPipeline();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+common
common/boardPkg.sv
common/colorPkg.sv
rtl/tileLocator.sv
rtl/tileClassifier.sv
rtl/paletteLookup.sv
rtl/colorMapper.sv
tb/colorMapperTb.sv

// File: Bender.yml
package:
  name: color_mapper

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/boardPkg.sv
      - common/colorPkg.sv
      - rtl/tileLocator.sv
      - rtl/tileClassifier.sv
      - rtl/paletteLookup.sv
      - rtl/colorMapper.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/colorMapperTb.sv
